// ==== sd_share_pkg.sv ====
/* sd card share dispatcher, common definitions
   port indexes, widths, per-port card layout and idle line levels */

package sd_share_pkg;

   //**************************************************
   // ports
   //**************************************************
   localparam int NUM_PORTS_DEF = 6;           // rk, dw, dm, db, dx, my
   localparam int PORT_IDX_W    = 3;           // owner index width

   typedef logic [PORT_IDX_W-1:0] port_idx_t;

   // lower index wins arbitration
   localparam port_idx_t PORT_RK = 3'd0;       // rk11 cartridge disk
   localparam port_idx_t PORT_DW = 3'd1;       // dw winchester
   localparam port_idx_t PORT_DM = 3'd2;       // rk611 disk
   localparam port_idx_t PORT_DB = 3'd3;       // rh70 massbus disk
   localparam port_idx_t PORT_DX = 3'd4;       // rx01 floppy
   localparam port_idx_t PORT_MY = 3'd5;       // my floppy

   //**************************************************
   // card layout
   //**************************************************
   localparam int BANK_W   = 4;                // disk bank switch
   localparam int BASE_W   = 22;               // per-port image base
   localparam int OFFSET_W = 27;               // 1 + bank + base

   typedef logic [OFFSET_W-1:0] card_offset_t;

   // image base per port, highest index first
   localparam logic [NUM_PORTS_DEF-1:0][BASE_W-1:0] CARD_BASE = {
      22'h02e000,                              // my
      22'h02c000,                              // dx
      22'h030000,                              // db
      22'h330000,                              // dm
      22'h00c000,                              // dw
      22'h000000                               // rk
   };

   // set bit = bank switch sits above the base
   // db image lives at a fixed place, bank ignored
   localparam logic [NUM_PORTS_DEF-1:0] BANK_FOLLOW =
      ~(NUM_PORTS_DEF'(1) << PORT_DB);

   //**************************************************
   // card lines with no owner
   //**************************************************
   localparam logic IDLE_CS   = 1'b1;          // card deselected
   localparam logic IDLE_MOSI = 1'b1;          // spi line idles high
   localparam logic IDLE_SCLK = 1'b0;          // clock parked low

endpackage

// ==== sd_req_sync.sv ====
/* sd card request filter
   two flops per port into the sdclock domain, plus activity leds */

module sd_req_sync #(
   parameter int NUM_PORTS = sd_share_pkg::NUM_PORTS_DEF
) (
   input  logic                 sdclock,
   input  logic                 reset_i,
   input  logic [NUM_PORTS-1:0] sd_req_i,     // raw controller requests
   output logic [NUM_PORTS-1:0] req_filt_o,   // filtered, two edges late
   output logic [NUM_PORTS-1:0] req_led_n_o   // active-low activity leds
);

   logic [NUM_PORTS-1:0] req_meta;            // first stage, may go metastable
   logic [NUM_PORTS-1:0] req_stable;          // second stage, clean

   //**************************************************
   // two-stage filter
   //**************************************************
   always_ff @(posedge sdclock) begin
      if (reset_i) begin
         req_meta   <= '0;
         req_stable <= '0;
      end else begin
         req_meta   <= sd_req_i;              // edge k
         req_stable <= req_meta;              // edge k+1
      end
   end

   assign req_filt_o = req_stable;

   // led lights on the raw request, even a short pulse
   assign req_led_n_o = ~sd_req_i;

endmodule

// ==== sd_grant_arbiter.sv ====
/* sd card grant arbiter
   fixed priority grant, held until the owner releases its request */

module sd_grant_arbiter #(
   parameter int NUM_PORTS = sd_share_pkg::NUM_PORTS_DEF
) (
   input  logic                    sdclock,
   input  logic                    reset_i,
   input  logic [NUM_PORTS-1:0]    req_filt_i,    // filtered requests
   output logic [NUM_PORTS-1:0]    grant_o,       // one-hot acknowledge
   output sd_share_pkg::port_idx_t owner_o,       // index of the granted port
   output logic                    owner_valid_o  // card is owned
);

   logic [NUM_PORTS-1:0]    grant_q;              // acknowledge register
   sd_share_pkg::port_idx_t owner_q;              // current owner
   logic                    owner_valid_q;        // grant held

   logic                    pick_valid;           // someone is waiting
   sd_share_pkg::port_idx_t pick_idx;             // lowest waiting index
   logic [NUM_PORTS-1:0]    pick_onehot;          // pick_idx as a grant word

   //**************************************************
   // priority pick, lowest index wins
   //**************************************************
   always_comb begin
      pick_idx    = '0;
      pick_onehot = '0;
      for (int i = NUM_PORTS - 1; i >= 0; i--) begin
         if (req_filt_i[i]) begin
            pick_idx = sd_share_pkg::port_idx_t'(i);   // overwritten by lower ports
         end
      end
      pick_valid = |req_filt_i;
      if (pick_valid) begin
         pick_onehot[pick_idx] = 1'b1;
      end
   end

   //**************************************************
   // grant register
   //**************************************************
   always_ff @(posedge sdclock) begin
      if (reset_i) begin
         grant_q       <= '0;
         owner_q       <= '0;
         owner_valid_q <= 1'b0;
      end else if (!owner_valid_q) begin
         // new grant only while idle
         if (pick_valid) begin
            grant_q       <= pick_onehot;
            owner_q       <= pick_idx;
            owner_valid_q <= 1'b1;
         end
      end else if (!req_filt_i[owner_q]) begin
         // owner let go so the card idles at least one cycle
         grant_q       <= '0;
         owner_q       <= '0;
         owner_valid_q <= 1'b0;
      end
   end

   assign grant_o       = grant_q;
   assign owner_o       = owner_q;
   assign owner_valid_o = owner_valid_q;

   //**************************************************
   // protocol checks
   //**************************************************
   a_grant_onehot0 : assert property (
      @(posedge sdclock) disable iff (reset_i)
      $onehot0(grant_q)
   );

   a_valid_is_any_grant : assert property (
      @(posedge sdclock) disable iff (reset_i)
      owner_valid_q == (|grant_q)
   );

   // a grant always passes through zero before another port gets it
   a_no_direct_handover : assert property (
      @(posedge sdclock) disable iff (reset_i)
      (|grant_q) |=> (grant_q == '0) || (grant_q == $past(grant_q))
   );

endmodule

// ==== sd_line_mux.sv ====
/* sd card line steering
   routes the owner's spi lines to the card and forms its image offset */

module sd_line_mux #(
   parameter int NUM_PORTS = sd_share_pkg::NUM_PORTS_DEF   // at most the table size
) (
   input  logic [NUM_PORTS-1:0]           grant_i,        // one-hot acknowledge
   input  sd_share_pkg::port_idx_t        owner_i,        // owner index
   input  logic                           owner_valid_i,  // card is owned
   input  logic [NUM_PORTS-1:0]           port_cs_i,      // per-port chip select
   input  logic [NUM_PORTS-1:0]           port_mosi_i,    // per-port data out
   input  logic [NUM_PORTS-1:0]           port_sclk_i,    // per-port spi clock
   input  logic [sd_share_pkg::BANK_W-1:0] disk_bank_i,   // static bank switch
   output logic                           sdcard_cs_o,
   output logic                           sdcard_mosi_o,
   output logic                           sdcard_sclk_o,
   output sd_share_pkg::card_offset_t     card_offset_o   // owner image start
);

   logic [sd_share_pkg::BANK_W-1:0] bank_sel;   // bank field of the offset
   logic [sd_share_pkg::BASE_W-1:0] base_sel;   // base field of the offset

   //**************************************************
   // spi lines
   //**************************************************
   // and-or select on the one-hot grant, idle levels with no owner
   always_comb begin
      if (owner_valid_i) begin
         sdcard_cs_o   = |(port_cs_i & grant_i);
         sdcard_mosi_o = |(port_mosi_i & grant_i);
         sdcard_sclk_o = |(port_sclk_i & grant_i);
      end else begin
         sdcard_cs_o   = sd_share_pkg::IDLE_CS;
         sdcard_mosi_o = sd_share_pkg::IDLE_MOSI;
         sdcard_sclk_o = sd_share_pkg::IDLE_SCLK;
      end
   end

   //**************************************************
   // card offset
   //**************************************************
   always_comb begin
      bank_sel = '0;
      base_sel = '0;
      if (owner_valid_i) begin
         base_sel = sd_share_pkg::CARD_BASE[owner_i];        // per-port table
         if (sd_share_pkg::BANK_FOLLOW[owner_i]) begin
            bank_sel = disk_bank_i;                          // db keeps zero
         end
      end
   end

   // top bit always zero, then bank, then base
   assign card_offset_o = {1'b0, bank_sel, base_sel};

   // owner index and grant word come from one register set in the arbiter
   always_comb begin
      if (owner_valid_i) begin
         a_owner_matches_grant : assert ($onehot(grant_i) && grant_i[owner_i]);
      end
   end

endmodule

// ==== sd_share_top.sv ====
/* sd card access dispatcher
   filters controller requests, grants the card by fixed priority, steers spi lines */

module sd_share_top #(
   parameter int NUM_PORTS = sd_share_pkg::NUM_PORTS_DEF
) (
   input  logic                            sdclock,        // card clock
   input  logic                            reset_i,        // sync, active high

   // controller side
   input  logic [NUM_PORTS-1:0]            sd_req_i,       // card requests
   output logic [NUM_PORTS-1:0]            sd_ack_o,       // card acknowledges
   input  logic [NUM_PORTS-1:0]            port_cs_i,      // controller cs lines
   input  logic [NUM_PORTS-1:0]            port_mosi_i,    // controller mosi lines
   input  logic [NUM_PORTS-1:0]            port_sclk_i,    // controller sclk lines

   // card side
   output logic                            sdcard_cs_o,
   output logic                            sdcard_mosi_o,
   output logic                            sdcard_sclk_o,

   // image placement
   input  logic [sd_share_pkg::BANK_W-1:0] disk_bank_i,    // bank switch
   output sd_share_pkg::card_offset_t      card_offset_o,  // owner image start

   // front panel
   output logic [NUM_PORTS-1:0]            req_led_n_o     // activity, active low
);

   logic [NUM_PORTS-1:0]    req_filt;      // filter -> arbiter
   logic [NUM_PORTS-1:0]    grant;         // arbiter -> mux and controllers
   sd_share_pkg::port_idx_t owner;         // arbiter -> mux
   logic                    owner_valid;   // arbiter -> mux

   //**************************************************
   // stage 1, request filter
   //**************************************************
   sd_req_sync #(
      .NUM_PORTS   (NUM_PORTS)
   ) req_sync_i (
      .sdclock     (sdclock),
      .reset_i     (reset_i),
      .sd_req_i    (sd_req_i),
      .req_filt_o  (req_filt),
      .req_led_n_o (req_led_n_o)
   );

   //**************************************************
   // stage 2, grant
   //**************************************************
   sd_grant_arbiter #(
      .NUM_PORTS     (NUM_PORTS)
   ) grant_arbiter_i (
      .sdclock       (sdclock),
      .reset_i       (reset_i),
      .req_filt_i    (req_filt),
      .grant_o       (grant),
      .owner_o       (owner),
      .owner_valid_o (owner_valid)
   );

   assign sd_ack_o = grant;   // grant is the acknowledge

   //**************************************************
   // stage 3, line steering
   //**************************************************
   sd_line_mux #(
      .NUM_PORTS     (NUM_PORTS)
   ) line_mux_i (
      .grant_i       (grant),
      .owner_i       (owner),
      .owner_valid_i (owner_valid),
      .port_cs_i     (port_cs_i),
      .port_mosi_i   (port_mosi_i),
      .port_sclk_i   (port_sclk_i),
      .disk_bank_i   (disk_bank_i),
      .sdcard_cs_o   (sdcard_cs_o),
      .sdcard_mosi_o (sdcard_mosi_o),
      .sdcard_sclk_o (sdcard_sclk_o),
      .card_offset_o (card_offset_o)
   );

endmodule

// ==== tb_sd_share.sv ====
/* sd card dispatcher testbench
   directed tests for request filter, priority grant, line steering and leds */

module tb_sd_share;

   localparam int NUM_PORTS      = 6;           // rk, dw, dm, db, dx, my
   localparam int ACK_EDGES      = 3;           // drive edge, then k, then ack at k+2
   localparam int ACK_WAIT_MAX   = 12;          // give up on a handshake after this
   localparam int EST_CYCLES     = 400;         // rough length of all tests
   localparam int TIMEOUT_CYCLES = 5 * EST_CYCLES;

   logic                 sdclock;
   logic                 reset_i;
   logic [NUM_PORTS-1:0] sd_req_i;
   logic [NUM_PORTS-1:0] sd_ack_o;
   logic [NUM_PORTS-1:0] port_cs_i;
   logic [NUM_PORTS-1:0] port_mosi_i;
   logic [NUM_PORTS-1:0] port_sclk_i;
   logic                 sdcard_cs_o;
   logic                 sdcard_mosi_o;
   logic                 sdcard_sclk_o;
   logic [3:0]           disk_bank_i;
   logic [26:0]          card_offset_o;
   logic [NUM_PORTS-1:0] req_led_n_o;

   int seed        = 88;                        // $random seed
   int err_count   = 0;                         // failed checks, all tests
   int tests_run   = 0;
   int tests_bad   = 0;
   int cycle_count = 0;

   sd_share_top dut_i (
      .sdclock       (sdclock),
      .reset_i       (reset_i),
      .sd_req_i      (sd_req_i),
      .sd_ack_o      (sd_ack_o),
      .port_cs_i     (port_cs_i),
      .port_mosi_i   (port_mosi_i),
      .port_sclk_i   (port_sclk_i),
      .sdcard_cs_o   (sdcard_cs_o),
      .sdcard_mosi_o (sdcard_mosi_o),
      .sdcard_sclk_o (sdcard_sclk_o),
      .disk_bank_i   (disk_bank_i),
      .card_offset_o (card_offset_o),
      .req_led_n_o   (req_led_n_o)
   );

   initial begin
      sdclock = 1'b0;
      forever #4 sdclock = ~sdclock;            // period 8
   end

   // runaway guard
   always @(posedge sdclock) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: run went past %0d cycles without finishing", TIMEOUT_CYCLES);
         $display("tests failed");
         $finish;
      end
   end

   //**************************************************
   // helpers
   //**************************************************
   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("FAILED %s: got %h expected %h", name, got, exp);
         err_count++;
      end
   endtask

   // image start per port: zero top bit, bank unless db, then base
   function automatic logic [26:0] expected_offset(input int port, input logic [3:0] bank);
      logic [21:0] base;
      logic [3:0]  bank_field;
      case (port)
         0:       base = 22'h000000;            // rk
         1:       base = 22'h00c000;            // dw
         2:       base = 22'h330000;            // dm
         3:       base = 22'h030000;            // db
         4:       base = 22'h02c000;            // dx
         default: base = 22'h02e000;            // my
      endcase
      bank_field = (port == 3) ? 4'h0 : bank;   // db image is fixed
      return {1'b0, bank_field, base};
   endfunction

   task automatic drive_req(input logic [NUM_PORTS-1:0] req);
      @(posedge sdclock);
      sd_req_i <= req;
   endtask

   task automatic drive_lines();
      logic [31:0] r;
      r = $random(seed);
      @(posedge sdclock);
      port_cs_i   <= r[5:0];
      port_mosi_i <= r[11:6];
      port_sclk_i <= r[17:12];
   endtask

   // counts edges until any ack reaches the wanted level, checks at negedge
   task automatic wait_for_ack(input logic want_high, output int edges);
      edges = 0;
      while (edges < ACK_WAIT_MAX) begin
         @(posedge sdclock);
         edges++;
         @(negedge sdclock);
         if ((|sd_ack_o) == want_high) break;
      end
      assert ((|sd_ack_o) == want_high) else begin
         $display("acknowledge did not %s within %0d cycles",
                  want_high ? "rise" : "fall", ACK_WAIT_MAX);
         err_count++;
      end
   endtask

   task automatic check_idle();
      check_val("sd_ack_o", sd_ack_o, 0);
      check_val("sdcard_cs_o", sdcard_cs_o, 1);
      check_val("sdcard_mosi_o", sdcard_mosi_o, 1);
      check_val("sdcard_sclk_o", sdcard_sclk_o, 0);
      check_val("card_offset_o", card_offset_o, 0);
   endtask

   task automatic check_leds();
      logic [NUM_PORTS-1:0] led_exp;
      led_exp = ~sd_req_i;                      // raw request, same cycle
      check_val("req_led_n_o", req_led_n_o, led_exp);
   endtask

   task automatic end_test(input string name, input int errs_before);
      tests_run++;
      if (err_count == errs_before) begin
         $display("test %s: ok", name);
      end else begin
         tests_bad++;
         $display("test %s: %0d errors", name, err_count - errs_before);
      end
   endtask

   //**************************************************
   // tests
   //**************************************************
   task automatic test_reset();
      int errs;
      errs = err_count;
      @(negedge sdclock);
      check_idle();
      check_val("req_led_n_o", req_led_n_o, 6'h3f);
      end_test("reset", errs);
   endtask

   task automatic test_single();
      int                   errs;
      int                   edges;
      logic [NUM_PORTS-1:0] bit_p;
      errs = err_count;
      for (int p = 0; p < NUM_PORTS; p++) begin
         bit_p = 6'b1 << p;
         @(posedge sdclock);
         disk_bank_i <= 4'(p + 9);               // nonzero bank per port
         drive_req(bit_p);
         wait_for_ack(1'b1, edges);
         check_val("ack latency", edges, ACK_EDGES);
         check_val("sd_ack_o", sd_ack_o, bit_p);
         repeat (4) begin
            drive_lines();
            @(negedge sdclock);
            check_val("sdcard_cs_o", sdcard_cs_o, port_cs_i[p]);
            check_val("sdcard_mosi_o", sdcard_mosi_o, port_mosi_i[p]);
            check_val("sdcard_sclk_o", sdcard_sclk_o, port_sclk_i[p]);
            check_val("card_offset_o", card_offset_o, expected_offset(p, disk_bank_i));
         end
         drive_req('0);
         wait_for_ack(1'b0, edges);
         check_val("release latency", edges, ACK_EDGES);
         check_idle();
      end
      end_test("single request", errs);
   endtask

   task automatic test_priority();
      int                   errs;
      int                   edges;
      logic [NUM_PORTS-1:0] masks [3];
      logic [NUM_PORTS-1:0] winners [3];
      errs = err_count;
      masks[0] = 6'b110100;                     // dm, dx, my
      winners[0] = 6'b000100;
      masks[1] = 6'b101010;                     // dw, db, my
      winners[1] = 6'b000010;
      masks[2] = 6'b111111;                     // everyone
      winners[2] = 6'b000001;
      for (int i = 0; i < 3; i++) begin
         drive_req(masks[i]);
         wait_for_ack(1'b1, edges);
         check_val("ack latency", edges, ACK_EDGES);
         check_val("sd_ack_o", sd_ack_o, winners[i]);
         drive_req('0);
         wait_for_ack(1'b0, edges);
      end
      end_test("priority", errs);
   endtask

   task automatic test_no_preempt();
      int errs;
      int edges;
      errs = err_count;
      drive_req(6'b001000);                     // db owns
      wait_for_ack(1'b1, edges);
      drive_req(6'b001011);                     // rk and dw arrive late
      repeat (6) begin
         @(negedge sdclock);
         check_val("sd_ack_o", sd_ack_o, 6'b001000);
         check_val("card_offset_o", card_offset_o, expected_offset(3, disk_bank_i));
         @(posedge sdclock);
      end
      drive_req('0);
      wait_for_ack(1'b0, edges);
      end_test("no pre-emption", errs);
   endtask

   task automatic test_handover();
      int errs;
      int edges;
      errs = err_count;
      drive_req(6'b010000);                     // dx owns
      wait_for_ack(1'b1, edges);
      drive_req(6'b110100);                     // dm and my wait
      repeat (3) begin
         @(negedge sdclock);
         check_val("sd_ack_o", sd_ack_o, 6'b010000);
         @(posedge sdclock);
      end
      drive_req(6'b100100);                     // dx lets go
      wait_for_ack(1'b0, edges);
      check_val("release latency", edges, ACK_EDGES);
      check_idle();                             // gap cycle between owners
      @(posedge sdclock);
      @(negedge sdclock);
      check_val("sd_ack_o", sd_ack_o, 6'b000100);   // dm, one edge later
      check_val("card_offset_o", card_offset_o, expected_offset(2, disk_bank_i));
      drive_req('0);
      wait_for_ack(1'b0, edges);
      end_test("release and handover", errs);
   endtask

   task automatic test_leds();
      int          errs;
      int          edges;
      logic [31:0] r;
      errs = err_count;
      drive_req(6'b000001);                     // rk holds the card
      wait_for_ack(1'b1, edges);
      check_leds();
      drive_req(6'b100001);                     // one-cycle pulse on my
      @(negedge sdclock);
      check_leds();
      drive_req(6'b000001);
      @(negedge sdclock);
      check_leds();
      repeat (4) begin
         r = $random(seed);
         drive_req({r[5:1], 1'b1});
         @(negedge sdclock);
         check_leds();
         check_val("sd_ack_o", sd_ack_o, 6'b000001);
      end
      drive_req('0);
      wait_for_ack(1'b0, edges);
      repeat (4) begin
         @(posedge sdclock);
         @(negedge sdclock);
         check_leds();
         check_val("sd_ack_o", sd_ack_o, 0);    // pulse never granted
      end
      end_test("leds", errs);
   endtask

   //**************************************************
   // main sequence
   //**************************************************
   initial begin
      reset_i     = 1'b1;
      sd_req_i    = '0;
      port_cs_i   = '0;
      port_mosi_i = '0;
      port_sclk_i = '0;
      disk_bank_i = '0;
      repeat (3) @(posedge sdclock);             // reset for 3 cycles
      reset_i <= 1'b0;

      test_reset();
      test_single();
      test_priority();
      test_no_preempt();
      test_handover();
      test_leds();

      $display("summary: %0d tests run, %0d with errors, %0d checks wrong",
               tests_run, tests_bad, err_count);
      if (err_count == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// ==== src.f ====
sd_share_pkg.sv
sd_req_sync.sv
sd_grant_arbiter.sv
sd_line_mux.sv
sd_share_top.sv
tb_sd_share.sv

// ==== Makefile ====
# Verilator build and run for the sd card dispatcher testbench
# override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_sd_share
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= all tests passed

# sources come from the file list, skipping option lines
SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation reported errors, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
